// ==== verilog/tomasulo_pkg.sv ====
`default_nettype none

package tomasulo_pkg;

    // Station tag, zero means the value is already present
    typedef logic [3:0] tag_t;

    // Architectural register index
    typedef logic [4:0] reg_idx_t;

    // Operand and result word
    typedef logic [31:0] data_t;

    localparam int NUM_REGS = 32;

    // First tag of each station bank
    localparam tag_t ADD_BASE_TAG = 4'd1;
    localparam tag_t MUL_BASE_TAG = 4'd4;

endpackage

`default_nettype wire

// ==== verilog/issue_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface issue_if
    import tomasulo_pkg::*;
();

    logic  alloc;
    logic  op;
    data_t vj;
    tag_t  qj;
    data_t vk;
    tag_t  qk;

    // Bank occupancy seen by the issue controller
    logic  full;
    logic  empty;
    tag_t  alloc_tag;

    modport ctrl (
        output alloc, op, vj, qj, vk, qk,
        input  full, empty, alloc_tag
    );

    modport bank (
        input  alloc, op, vj, qj, vk, qk,
        output full, empty, alloc_tag
    );

endinterface

`default_nettype wire

// ==== verilog/reg_status.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_status
    import tomasulo_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  reg_idx_t rs,
    input  reg_idx_t rt,
    input  logic     rename_en,
    input  reg_idx_t rename_reg,
    input  tag_t     rename_tag,
    input  logic     cdb_valid,
    input  tag_t     cdb_tag,
    input  data_t    cdb_data,
    output tag_t     qi_rs,
    output tag_t     qi_rt,
    output logic     reg_write_valid,
    output reg_idx_t reg_write_addr,
    output data_t    reg_write_data
);

    tag_t     qi [NUM_REGS];
    logic     hit;
    reg_idx_t hit_reg;
    logic     wb_take;

    assign qi_rs = qi[rs];
    assign qi_rt = qi[rt];

    // A tag names at most one register at a time
    always_comb begin
        hit     = 1'b0;
        hit_reg = '0;
        for (int i = 0; i < NUM_REGS; i++) begin
            if (cdb_valid && cdb_tag != '0 && qi[i] == cdb_tag) begin
                hit     = 1'b1;
                hit_reg = reg_idx_t'(i);
            end
        end
    end

    // Renamed at this very edge, so the broadcast value is already stale
    assign wb_take = hit && !(rename_en && rename_reg == hit_reg);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                qi[i] <= '0;
            end
            reg_write_valid <= 1'b0;
        end else begin
            reg_write_valid <= wb_take;
            // Entry stays named until the write reaches the register file
            if (reg_write_valid) begin
                qi[reg_write_addr] <= '0;
            end
            // Later rename wins over the clear
            if (rename_en) begin
                qi[rename_reg] <= rename_tag;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wb_take) begin
            reg_write_addr <= hit_reg;
            reg_write_data <= cdb_data;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/issue_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_ctrl
    import tomasulo_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     add_en,
    input  logic     mul_en,
    input  logic     imminstr,
    input  logic     isadd,
    input  logic     ismultiply,
    input  reg_idx_t rs,
    input  reg_idx_t rt,
    input  reg_idx_t rd,
    input  data_t    ext_imm,
    input  data_t    read_data1,
    input  data_t    read_data2,
    input  tag_t     qi_rs,
    input  tag_t     qi_rt,
    input  logic     cdb_valid,
    input  tag_t     cdb_tag,
    input  data_t    cdb_data,
    issue_if.ctrl    add_port,
    issue_if.ctrl    mul_port,
    output logic     rename_en,
    output reg_idx_t rename_reg,
    output tag_t     rename_tag,
    output logic     a_stall,
    output logic     done
);

    logic  instr_valid;
    logic  add_take;
    logic  mul_take;
    logic  last_valid;
    tag_t  last_tag;
    data_t last_data;
    data_t vj;
    data_t vk;
    tag_t  qj;
    tag_t  qk;
    logic  issued;
    logic  drained;

    // Previous broadcast covers the cycle before the register file write lands
    function automatic void resolve(
        input  tag_t  qi,
        input  data_t rdata,
        output data_t v,
        output tag_t  q
    );
        v = rdata;
        q = '0;
        if (qi != '0) begin
            if (cdb_valid && cdb_tag == qi) begin
                v = cdb_data;
            end else if (last_valid && last_tag == qi) begin
                v = last_data;
            end else begin
                v = '0;
                q = qi;
            end
        end
    endfunction

    always_comb begin
        resolve(qi_rs, read_data1, vj, qj);
        resolve(qi_rt, read_data2, vk, qk);
    end

    // All-zero fields mark an empty slot
    assign instr_valid = (rs != '0) || (rt != '0) || (rd != '0);
    assign add_take    = add_en && instr_valid && !add_port.full;
    assign mul_take    = mul_en && !add_en && instr_valid && !mul_port.full;

    assign add_port.alloc = add_take;
    assign add_port.op    = isadd;
    assign add_port.vj    = vj;
    assign add_port.qj    = qj;
    assign add_port.vk    = imminstr ? ext_imm : vk;
    assign add_port.qk    = imminstr ? tag_t'(0) : qk;

    assign mul_port.alloc = mul_take;
    assign mul_port.op    = ismultiply;
    assign mul_port.vj    = vj;
    assign mul_port.qj    = qj;
    assign mul_port.vk    = vk;
    assign mul_port.qk    = qk;

    assign rename_en  = add_take || mul_take;
    assign rename_reg = rd;
    assign rename_tag = add_take ? add_port.alloc_tag : mul_port.alloc_tag;

    assign a_stall = (add_en && add_port.full) || (mul_en && mul_port.full);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            last_valid <= 1'b0;
            issued     <= 1'b0;
            drained    <= 1'b0;
            done       <= 1'b0;
        end else begin
            last_valid <= cdb_valid;
            if (rename_en) begin
                issued <= 1'b1;
            end
            drained <= issued && add_port.empty && mul_port.empty;
            // Sticky once set
            if (drained) begin
                done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cdb_valid) begin
            last_tag  <= cdb_tag;
            last_data <= cdb_data;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/rs_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module rs_bank
    import tomasulo_pkg::*;
#(
    parameter int   NUM_ENTRIES = 3,
    parameter tag_t BASE_TAG    = ADD_BASE_TAG
) (
    input  logic                    clk,
    input  logic                    reset,
    issue_if.bank                   issue,
    input  logic                    cdb_valid,
    input  tag_t                    cdb_tag,
    input  data_t                   cdb_data,
    output logic  [NUM_ENTRIES-1:0] start,
    output logic  [NUM_ENTRIES-1:0] unit_op,
    output data_t [NUM_ENTRIES-1:0] src_a,
    output data_t [NUM_ENTRIES-1:0] src_b,
    output tag_t  [NUM_ENTRIES-1:0] unit_tag
);

    localparam int IDX_W = (NUM_ENTRIES > 1) ? $clog2(NUM_ENTRIES) : 1;

    logic  [NUM_ENTRIES-1:0] busy;
    logic  [NUM_ENTRIES-1:0] fired;
    logic  [NUM_ENTRIES-1:0] op;
    data_t [NUM_ENTRIES-1:0] vj;
    data_t [NUM_ENTRIES-1:0] vk;
    tag_t  [NUM_ENTRIES-1:0] qj;
    tag_t  [NUM_ENTRIES-1:0] qk;

    logic  [NUM_ENTRIES-1:0] ready;
    logic  [NUM_ENTRIES-1:0] wake_j;
    logic  [NUM_ENTRIES-1:0] wake_k;
    logic  [NUM_ENTRIES-1:0] own_hit;
    logic  [NUM_ENTRIES-1:0] alloc_sel;
    logic  [IDX_W-1:0]       free_idx;

    // Fixed tag of each entry
    function automatic tag_t entry_tag(input int idx);
        return BASE_TAG + tag_t'(idx);
    endfunction

    // Lowest free entry
    always_comb begin
        free_idx = '0;
        for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                free_idx = IDX_W'(i);
            end
        end
    end

    assign issue.full      = &busy;
    assign issue.empty     = ~|busy;
    assign issue.alloc_tag = entry_tag(int'(free_idx));

    always_comb begin
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            ready[i]     = busy[i] && !fired[i] && qj[i] == '0 && qk[i] == '0;
            wake_j[i]    = cdb_valid && qj[i] != '0 && qj[i] == cdb_tag;
            wake_k[i]    = cdb_valid && qk[i] != '0 && qk[i] == cdb_tag;
            own_hit[i]   = cdb_valid && cdb_tag == entry_tag(i);
            alloc_sel[i] = issue.alloc && free_idx == IDX_W'(i);
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy  <= '0;
            fired <= '0;
            qj    <= '0;
            qk    <= '0;
            start <= '0;
        end else begin
            // One pulse per dispatch, fired blocks a second one
            start <= ready;
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                if (ready[i]) begin
                    fired[i] <= 1'b1;
                end
                if (wake_j[i]) begin
                    qj[i] <= '0;
                end
                if (wake_k[i]) begin
                    qk[i] <= '0;
                end
                // Result of this station is on the CDB
                if (own_hit[i]) begin
                    busy[i]  <= 1'b0;
                    fired[i] <= 1'b0;
                end
                if (alloc_sel[i]) begin
                    busy[i]  <= 1'b1;
                    fired[i] <= 1'b0;
                    qj[i]    <= issue.qj;
                    qk[i]    <= issue.qk;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            // Unit inputs hold until the next dispatch
            if (ready[i]) begin
                unit_op[i]  <= op[i];
                src_a[i]    <= vj[i];
                src_b[i]    <= vk[i];
                unit_tag[i] <= entry_tag(i);
            end
            if (wake_j[i]) begin
                vj[i] <= cdb_data;
            end
            if (wake_k[i]) begin
                vk[i] <= cdb_data;
            end
            if (alloc_sel[i]) begin
                op[i] <= issue.op;
                vj[i] <= issue.vj;
                vk[i] <= issue.vk;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/reservation_station_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module reservation_station_top
    import tomasulo_pkg::*;
#(
    parameter int NUM_ADD = 3,
    parameter int NUM_MUL = 2
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                add_en,
    input  logic                mul_en,
    input  logic                imminstr,
    input  logic                isadd,
    input  logic                ismultiply,
    input  reg_idx_t            rs,
    input  reg_idx_t            rt,
    input  reg_idx_t            rd,
    input  data_t               ext_imm,
    input  logic                cdb_valid,
    input  tag_t                cdb_tag,
    input  data_t               cdb_data,
    output reg_idx_t            read_addr1,
    output reg_idx_t            read_addr2,
    input  data_t               read_data1,
    input  data_t               read_data2,
    output logic  [NUM_ADD-1:0] adder_start,
    output logic  [NUM_ADD-1:0] adder_isadd,
    output data_t [NUM_ADD-1:0] adder_src_a,
    output data_t [NUM_ADD-1:0] adder_src_b,
    output tag_t  [NUM_ADD-1:0] adder_tag,
    output logic  [NUM_MUL-1:0] multi_start,
    output logic  [NUM_MUL-1:0] multi_ismultiply,
    output data_t [NUM_MUL-1:0] multi_src_a,
    output data_t [NUM_MUL-1:0] multi_src_b,
    output tag_t  [NUM_MUL-1:0] multi_tag,
    output logic                reg_write_valid,
    output reg_idx_t            reg_write_addr,
    output data_t               reg_write_data,
    output logic                a_stall,
    output logic                done
);

    tag_t     qi_rs;
    tag_t     qi_rt;
    logic     rename_en;
    reg_idx_t rename_reg;
    tag_t     rename_tag;

    issue_if add_if ();
    issue_if mul_if ();

    // Register file is read straight from the instruction fields
    assign read_addr1 = rs;
    assign read_addr2 = rt;

    reg_status reg_status_inst (
        .clk             (clk),
        .reset           (reset),
        .rs              (rs),
        .rt              (rt),
        .rename_en       (rename_en),
        .rename_reg      (rename_reg),
        .rename_tag      (rename_tag),
        .cdb_valid       (cdb_valid),
        .cdb_tag         (cdb_tag),
        .cdb_data        (cdb_data),
        .qi_rs           (qi_rs),
        .qi_rt           (qi_rt),
        .reg_write_valid (reg_write_valid),
        .reg_write_addr  (reg_write_addr),
        .reg_write_data  (reg_write_data)
    );

    issue_ctrl issue_ctrl_inst (
        .clk        (clk),
        .reset      (reset),
        .add_en     (add_en),
        .mul_en     (mul_en),
        .imminstr   (imminstr),
        .isadd      (isadd),
        .ismultiply (ismultiply),
        .rs         (rs),
        .rt         (rt),
        .rd         (rd),
        .ext_imm    (ext_imm),
        .read_data1 (read_data1),
        .read_data2 (read_data2),
        .qi_rs      (qi_rs),
        .qi_rt      (qi_rt),
        .cdb_valid  (cdb_valid),
        .cdb_tag    (cdb_tag),
        .cdb_data   (cdb_data),
        .add_port   (add_if.ctrl),
        .mul_port   (mul_if.ctrl),
        .rename_en  (rename_en),
        .rename_reg (rename_reg),
        .rename_tag (rename_tag),
        .a_stall    (a_stall),
        .done       (done)
    );

    rs_bank #(
        .NUM_ENTRIES (NUM_ADD),
        .BASE_TAG    (ADD_BASE_TAG)
    ) add_bank_inst (
        .clk       (clk),
        .reset     (reset),
        .issue     (add_if.bank),
        .cdb_valid (cdb_valid),
        .cdb_tag   (cdb_tag),
        .cdb_data  (cdb_data),
        .start     (adder_start),
        .unit_op   (adder_isadd),
        .src_a     (adder_src_a),
        .src_b     (adder_src_b),
        .unit_tag  (adder_tag)
    );

    rs_bank #(
        .NUM_ENTRIES (NUM_MUL),
        .BASE_TAG    (MUL_BASE_TAG)
    ) mul_bank_inst (
        .clk       (clk),
        .reset     (reset),
        .issue     (mul_if.bank),
        .cdb_valid (cdb_valid),
        .cdb_tag   (cdb_tag),
        .cdb_data  (cdb_data),
        .start     (multi_start),
        .unit_op   (multi_ismultiply),
        .src_a     (multi_src_a),
        .src_b     (multi_src_b),
        .unit_tag  (multi_tag)
    );

endmodule

`default_nettype wire

// ==== bench/rs_bank_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module rs_bank_assert #(
    parameter int NUM_ENTRIES = 3
) (
    input logic                   clk,
    input logic                   reset,
    input logic [NUM_ENTRIES-1:0] busy,
    input logic [NUM_ENTRIES-1:0] start,
    input logic [NUM_ENTRIES-1:0] alloc_sel
);

    int fail_count = 0;

    // New station only while one is free
    a_alloc_not_full: assert property (@(posedge clk) disable iff (reset)
        (|alloc_sel) |-> !(&busy))
        else begin
            $error("alloc raised while the bank is full");
            fail_count++;
        end

    for (genvar i = 0; i < NUM_ENTRIES; i++) begin : g_entry
        a_start_pulse: assert property (@(posedge clk) disable iff (reset)
            start[i] |=> !start[i])
            else begin
                $error("start of entry %0d lasted two cycles", i);
                fail_count++;
            end

        a_start_busy: assert property (@(posedge clk) disable iff (reset)
            start[i] |-> busy[i])
            else begin
                $error("start of entry %0d while the entry is idle", i);
                fail_count++;
            end
    end

endmodule

bind rs_bank rs_bank_assert #(
    .NUM_ENTRIES (NUM_ENTRIES)
) bank_assert_inst (
    .clk       (clk),
    .reset     (reset),
    .busy      (busy),
    .start     (start),
    .alloc_sel (alloc_sel)
);

`default_nettype wire

// ==== bench/tb_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_top
    import tomasulo_pkg::*;
();

    localparam int NUM_ADD    = 3;
    localparam int NUM_MUL    = 2;
    localparam int NUM_TAGS   = 6;
    localparam int NUM_INSTR  = 200;
    localparam int MAX_CYCLES = NUM_INSTR * 20;

    logic                clk;
    logic                reset;
    logic                add_en;
    logic                mul_en;
    logic                imminstr;
    logic                isadd;
    logic                ismultiply;
    reg_idx_t            rs;
    reg_idx_t            rt;
    reg_idx_t            rd;
    data_t               ext_imm;
    logic                cdb_valid;
    tag_t                cdb_tag;
    data_t               cdb_data;
    reg_idx_t            read_addr1;
    reg_idx_t            read_addr2;
    data_t               read_data1;
    data_t               read_data2;
    logic  [NUM_ADD-1:0] adder_start;
    logic  [NUM_ADD-1:0] adder_isadd;
    data_t [NUM_ADD-1:0] adder_src_a;
    data_t [NUM_ADD-1:0] adder_src_b;
    tag_t  [NUM_ADD-1:0] adder_tag;
    logic  [NUM_MUL-1:0] multi_start;
    logic  [NUM_MUL-1:0] multi_ismultiply;
    data_t [NUM_MUL-1:0] multi_src_a;
    data_t [NUM_MUL-1:0] multi_src_b;
    tag_t  [NUM_MUL-1:0] multi_tag;
    logic                reg_write_valid;
    reg_idx_t            reg_write_addr;
    data_t               reg_write_data;
    logic                a_stall;
    logic                done;

    // Register file seen by the DUT, and the in-order reference state
    data_t       rf [NUM_REGS];
    data_t       model_rf [NUM_REGS];
    tag_t        latest [NUM_REGS];
    logic        busy_m [NUM_TAGS];
    data_t       exp_a [NUM_TAGS];
    data_t       exp_b [NUM_TAGS];
    logic        exp_op [NUM_TAGS];
    logic        res_valid [NUM_TAGS];
    data_t       res_data [NUM_TAGS];
    int          res_due [NUM_TAGS];
    logic        wr_exp;
    reg_idx_t    wr_addr_exp;
    data_t       wr_data_exp;
    logic        issued_m;
    logic        drained_m;
    logic        done_m;
    logic        cur_valid;
    int          gen_count;
    int          cycles;
    int          errors;
    int          checks;
    logic [31:0] rng;

    assign read_data1 = rf[read_addr1];
    assign read_data2 = rf[read_addr2];

    reservation_station_top #(
        .NUM_ADD (NUM_ADD),
        .NUM_MUL (NUM_MUL)
    ) reservation_station_top_inst (
        .clk              (clk),
        .reset            (reset),
        .add_en           (add_en),
        .mul_en           (mul_en),
        .imminstr         (imminstr),
        .isadd            (isadd),
        .ismultiply       (ismultiply),
        .rs               (rs),
        .rt               (rt),
        .rd               (rd),
        .ext_imm          (ext_imm),
        .cdb_valid        (cdb_valid),
        .cdb_tag          (cdb_tag),
        .cdb_data         (cdb_data),
        .read_addr1       (read_addr1),
        .read_addr2       (read_addr2),
        .read_data1       (read_data1),
        .read_data2       (read_data2),
        .adder_start      (adder_start),
        .adder_isadd      (adder_isadd),
        .adder_src_a      (adder_src_a),
        .adder_src_b      (adder_src_b),
        .adder_tag        (adder_tag),
        .multi_start      (multi_start),
        .multi_ismultiply (multi_ismultiply),
        .multi_src_a      (multi_src_a),
        .multi_src_b      (multi_src_b),
        .multi_tag        (multi_tag),
        .reg_write_valid  (reg_write_valid),
        .reg_write_addr   (reg_write_addr),
        .reg_write_data   (reg_write_data),
        .a_stall          (a_stall),
        .done             (done)
    );

    function automatic logic [31:0] lcg(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int busy_count(input int first, input int num);
        int n;
        n = 0;
        for (int i = first; i < first + num; i++) begin
            if (busy_m[i]) begin
                n++;
            end
        end
        return n;
    endfunction

    // Lowest free station of a bank
    function automatic int free_tag(input int first, input int num);
        int t;
        t = 0;
        for (int i = first + num - 1; i >= first; i--) begin
            if (!busy_m[i]) begin
                t = i;
            end
        end
        return t;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic load_instr();
        logic        kind_mul;
        logic [31:0] r;
        rng = lcg(rng);
        r = rng;
        // One in four is a multiply, few registers for dependencies
        kind_mul = (r[31:30] == 2'b11);
        add_en     <= !kind_mul;
        mul_en     <= kind_mul;
        imminstr   <= !kind_mul && (r[29:28] == 2'b00);
        isadd      <= !kind_mul && r[27];
        ismultiply <= kind_mul;
        rs         <= reg_idx_t'(r[26:24] % 6);
        rt         <= reg_idx_t'(r[23:21] % 6);
        rd         <= reg_idx_t'(1 + r[20:18] % 5);
        rng = lcg(rng);
        ext_imm    <= rng;
    endtask

    task automatic accept_instr();
        int    t;
        data_t a;
        data_t b;
        t = add_en ? free_tag(ADD_BASE_TAG, NUM_ADD) : free_tag(MUL_BASE_TAG, NUM_MUL);
        a = model_rf[rs];
        b = imminstr ? ext_imm : model_rf[rt];
        exp_a[t]   = a;
        exp_b[t]   = b;
        exp_op[t]  = add_en ? isadd : ismultiply;
        busy_m[t]  = 1'b1;
        latest[rd] = tag_t'(t);
        if (mul_en) begin
            model_rf[rd] = a * b;
        end else if (isadd) begin
            model_rf[rd] = a + b;
        end else begin
            model_rf[rd] = a - b;
        end
    endtask

    // Functional unit takes the operands and queues its result
    task automatic unit_start(input string prefix, input int t, input tag_t got_tag,
                              input logic got_op, input data_t a, input data_t b,
                              input logic is_mul);
        check_value({prefix, "_tag"}, got_tag, t);
        check_value({prefix, "_src_a"}, a, exp_a[t]);
        check_value({prefix, "_src_b"}, b, exp_b[t]);
        check_value({prefix, "_op"}, got_op, exp_op[t]);
        if (!busy_m[t]) begin
            errors++;
            $display("Error: station %0d started with no instruction issued to it", t);
        end
        rng = lcg(rng);
        res_valid[t] = 1'b1;
        res_due[t]   = cycles + 1 + int'(rng[31:16] % 6);
        if (is_mul) begin
            res_data[t] = a * b;
        end else begin
            res_data[t] = got_op ? a + b : a - b;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Error: done did not rise within %0d cycles", MAX_CYCLES);
            $display("Simulation FAILED");
            $finish;
        end
    end

    always @(posedge clk) begin : model_step
        int   pick;
        logic stall_exp;
        if (!reset) begin
            // Done follows the drain by two edges
            check_value("done", done, done_m);
            done_m    = done_m | drained_m;
            drained_m = issued_m && busy_count(1, NUM_TAGS - 1) == 0;

            check_value("reg_write_valid", reg_write_valid, wr_exp);
            if (wr_exp) begin
                check_value("reg_write_addr", reg_write_addr, wr_addr_exp);
                check_value("reg_write_data", reg_write_data, wr_data_exp);
            end
            if (reg_write_valid) begin
                rf[reg_write_addr] <= reg_write_data;
            end

            stall_exp = (add_en && busy_count(ADD_BASE_TAG, NUM_ADD) == NUM_ADD) ||
                        (mul_en && busy_count(MUL_BASE_TAG, NUM_MUL) == NUM_MUL);
            check_value("a_stall", a_stall, stall_exp);
            if (cur_valid && !stall_exp) begin
                accept_instr();
                issued_m  = 1'b1;
                cur_valid = 1'b0;
            end

            // Broadcast frees the station, the latest writer gets the write
            wr_exp = 1'b0;
            if (cdb_valid) begin
                busy_m[cdb_tag] = 1'b0;
                for (int r = 0; r < NUM_REGS; r++) begin
                    if (latest[r] == cdb_tag) begin
                        wr_exp      = 1'b1;
                        wr_addr_exp = reg_idx_t'(r);
                        wr_data_exp = cdb_data;
                        latest[r]   = '0;
                    end
                end
            end

            for (int i = 0; i < NUM_ADD; i++) begin
                if (adder_start[i]) begin
                    unit_start("adder", ADD_BASE_TAG + i, adder_tag[i], adder_isadd[i],
                               adder_src_a[i], adder_src_b[i], 1'b0);
                end
            end
            for (int i = 0; i < NUM_MUL; i++) begin
                if (multi_start[i]) begin
                    unit_start("multi", MUL_BASE_TAG + i, multi_tag[i], multi_ismultiply[i],
                               multi_src_a[i], multi_src_b[i], 1'b1);
                end
            end

            pick = 0;
            for (int t = NUM_TAGS - 1; t >= 1; t--) begin
                if (res_valid[t] && res_due[t] <= cycles) begin
                    pick = t;
                end
            end
            if (pick != 0) begin
                res_valid[pick] = 1'b0;
                cdb_valid <= 1'b1;
                cdb_tag   <= tag_t'(pick);
                cdb_data  <= res_data[pick];
            end else begin
                cdb_valid <= 1'b0;
            end

            if (!cur_valid && gen_count < NUM_INSTR) begin
                load_instr();
                gen_count++;
                cur_valid = 1'b1;
            end else if (!cur_valid) begin
                add_en <= 1'b0;
                mul_en <= 1'b0;
                rs     <= '0;
                rt     <= '0;
                rd     <= '0;
            end
        end
    end

    initial begin : run
        int afails;
        rng        = 32'h99a4b193;
        reset      = 1'b1;
        add_en     = 1'b0;
        mul_en     = 1'b0;
        imminstr   = 1'b0;
        isadd      = 1'b0;
        ismultiply = 1'b0;
        rs         = '0;
        rt         = '0;
        rd         = '0;
        ext_imm    = '0;
        cdb_valid  = 1'b0;
        cdb_tag    = '0;
        cdb_data   = '0;
        wr_exp     = 1'b0;
        issued_m   = 1'b0;
        drained_m  = 1'b0;
        done_m     = 1'b0;
        cur_valid  = 1'b0;
        gen_count  = 0;
        cycles     = 0;
        errors     = 0;
        checks     = 0;
        for (int i = 0; i < NUM_REGS; i++) begin
            rf[i]       = 32'h1000_0003 + i * 32'h0101_0101;
            model_rf[i] = 32'h1000_0003 + i * 32'h0101_0101;
            latest[i]   = '0;
        end
        for (int t = 0; t < NUM_TAGS; t++) begin
            busy_m[t]    = 1'b0;
            res_valid[t] = 1'b0;
        end
        repeat (16) @(posedge clk);
        reset <= 1'b0;

        wait (gen_count == NUM_INSTR && !cur_valid && done === 1'b1);
        // Done must hold while the run winds down
        repeat (4) @(posedge clk);
        for (int i = 0; i < NUM_REGS; i++) begin
            check_value($sformatf("rf[%0d]", i), rf[i], model_rf[i]);
        end
        afails = reservation_station_top_inst.add_bank_inst.bank_assert_inst.fail_count +
                 reservation_station_top_inst.mul_bank_inst.bank_assert_inst.fail_count;
        $display("Checks: %0d, errors: %0d, assertion failures: %0d", checks, errors, afails);
        if (errors == 0 && afails == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
verilog/tomasulo_pkg.sv
verilog/issue_if.sv
verilog/reg_status.sv
verilog/issue_ctrl.sv
verilog/rs_bank.sv
verilog/reservation_station_top.sv
bench/rs_bank_assert.sv
bench/tb_top.sv
